// File: hdl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_count = 16;
    localparam logic [31:0] reset_vector = 32'h0000_0000;

    // base opcodes
    localparam logic [6:0] opc_op = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui = 7'b0110111;
    localparam logic [6:0] opc_auipc = 7'b0010111;
    localparam logic [6:0] opc_jal = 7'b1101111;
    localparam logic [6:0] opc_jalr = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;
    localparam logic [6:0] opc_load = 7'b0000011;
    localparam logic [6:0] opc_store = 7'b0100011;
    localparam logic [6:0] opc_system = 7'b1110011;

    localparam logic [11:0] csr_mstatus = 12'h300;
    localparam logic [11:0] csr_mtvec = 12'h305;
    localparam logic [11:0] csr_mepc = 12'h341;
    localparam logic [11:0] csr_mcause = 12'h342;

    // mstatus bit positions
    localparam int mstatus_mie = 3;
    localparam int mstatus_mpie = 7;

    localparam logic [31:0] cause_ecall_m = 32'd11;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six layouts
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        csr_none,
        csr_write,
        csr_set
    } csr_op_e;

    typedef struct packed {
        logic [3:0]  rs1;
        logic [3:0]  rs2;
        logic [3:0]  rd;
        logic        rd_wen;
        alu_op_e     alu_op;
        logic        a_is_pc;
        logic        b_is_imm;
        logic        is_branch;
        logic [2:0]  br_funct;
        logic        is_jal;
        logic        is_jalr;
        logic        mem_read;
        logic        mem_write;
        csr_op_e     csr_op;
        logic [11:0] csr_addr;
        logic        is_ecall;
        logic        is_mret;
        logic [31:0] imm;
    } ctrl_t;

    typedef struct packed {
        logic        ren;
        logic        wen;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        rd_wen;
        logic [3:0]  rd;
        logic [31:0] rd_data;
    } retire_t;

endpackage

`default_nettype wire

// File: hdl/cpu_ifu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_ifu (
    input  wire         clk,
    input  wire         rst,
    input  wire         redirect,
    input  wire  [31:0] target,
    input  wire         trap,
    input  wire  [31:0] trap_pc,
    output logic [31:0] pc
);

    logic [31:0] pc_next;

    // trap beats jump/branch, which beats fall-through
    always_comb begin
        if (trap) begin
            pc_next = trap_pc;
        end else if (redirect) begin
            pc_next = target;
        end else begin
            pc_next = pc + 32'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= cpu_pkg::reset_vector;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_idu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_idu (
    input  wire cpu_pkg::inst_u inst,
    output cpu_pkg::ctrl_t      ctrl
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;

    function automatic cpu_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000: alu_decode = alt ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
            3'b001: alu_decode = cpu_pkg::alu_sll;
            3'b010: alu_decode = cpu_pkg::alu_slt;
            3'b011: alu_decode = cpu_pkg::alu_sltu;
            3'b100: alu_decode = cpu_pkg::alu_xor;
            3'b101: alu_decode = alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
            3'b110: alu_decode = cpu_pkg::alu_or;
            default: alu_decode = cpu_pkg::alu_and;
        endcase
    endfunction

    // sign-extended immediates, one per layout
    assign imm_i = {{20{inst.i_fmt.imm_11_0[11]}}, inst.i_fmt.imm_11_0};
    assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    assign imm_b = {{19{inst.b_fmt.imm_12}}, inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {{11{inst.j_fmt.imm_20}}, inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        ctrl = '0;
        // RV32E drops the top bit of each register field
        ctrl.rs1 = inst.r_fmt.rs1[3:0];
        ctrl.rs2 = inst.r_fmt.rs2[3:0];
        ctrl.rd = inst.r_fmt.rd[3:0];
        ctrl.alu_op = cpu_pkg::alu_add;
        ctrl.br_funct = inst.r_fmt.funct3;
        ctrl.csr_addr = inst.i_fmt.imm_11_0;
        case (inst.r_fmt.opcode)
            cpu_pkg::opc_op: begin
                ctrl.rd_wen = 1'b1;
                ctrl.alu_op = alu_decode(inst.r_fmt.funct3, inst.r_fmt.funct7[5]);
            end
            cpu_pkg::opc_op_imm: begin
                ctrl.rd_wen = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.imm = imm_i;
                // only srai uses the alternate encoding
                ctrl.alu_op = alu_decode(inst.r_fmt.funct3,
                                         inst.r_fmt.funct3 == 3'b101 && inst.r_fmt.funct7[5]);
            end
            cpu_pkg::opc_lui: begin
                ctrl.rd_wen = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.alu_op = cpu_pkg::alu_pass_b;
                ctrl.imm = imm_u;
            end
            cpu_pkg::opc_auipc: begin
                ctrl.rd_wen = 1'b1;
                ctrl.a_is_pc = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.imm = imm_u;
            end
            cpu_pkg::opc_jal: begin
                ctrl.rd_wen = 1'b1;
                ctrl.is_jal = 1'b1;
                ctrl.imm = imm_j;
            end
            cpu_pkg::opc_jalr: begin
                ctrl.rd_wen = 1'b1;
                ctrl.is_jalr = 1'b1;
                ctrl.imm = imm_i;
            end
            cpu_pkg::opc_branch: begin
                ctrl.is_branch = 1'b1;
                ctrl.imm = imm_b;
            end
            cpu_pkg::opc_load: begin
                // word loads only
                if (inst.i_fmt.funct3 == 3'b010) begin
                    ctrl.rd_wen = 1'b1;
                    ctrl.mem_read = 1'b1;
                    ctrl.b_is_imm = 1'b1;
                    ctrl.imm = imm_i;
                end
            end
            cpu_pkg::opc_store: begin
                if (inst.s_fmt.funct3 == 3'b010) begin
                    ctrl.mem_write = 1'b1;
                    ctrl.b_is_imm = 1'b1;
                    ctrl.imm = imm_s;
                end
            end
            cpu_pkg::opc_system: begin
                case (inst.i_fmt.funct3)
                    3'b000: begin
                        ctrl.is_ecall = inst.i_fmt.imm_11_0 == 12'h000;
                        ctrl.is_mret = inst.i_fmt.imm_11_0 == 12'h302;
                    end
                    3'b001: begin
                        ctrl.rd_wen = 1'b1;
                        ctrl.csr_op = cpu_pkg::csr_write;
                    end
                    3'b010: begin
                        ctrl.rd_wen = 1'b1;
                        ctrl.csr_op = cpu_pkg::csr_set;
                    end
                    default: ;
                endcase
            end
            default: ;
        endcase
        // x0 is never a destination
        ctrl.rd_wen = ctrl.rd_wen && (ctrl.rd != 4'd0);
    end

endmodule

`default_nettype wire

// File: hdl/cpu_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_regfile (
    input  wire         clk,
    input  wire         rst,
    input  wire         wen,
    input  wire  [3:0]  waddr,
    input  wire  [31:0] wdata,
    input  wire  [3:0]  raddr1,
    input  wire  [3:0]  raddr2,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] regs [cpu_pkg::reg_count];

    // entry 0 is cleared and never written, so it stays zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < cpu_pkg::reg_count; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != 4'd0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: hdl/cpu_exu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_exu (
    input  wire cpu_pkg::ctrl_t ctrl,
    input  wire  [31:0]         pc,
    input  wire  [31:0]         rs1_data,
    input  wire  [31:0]         rs2_data,
    output logic [31:0]         alu_result,
    output logic                redirect,
    output logic [31:0]         target
);

    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [4:0]  shamt;
    logic        taken;

    assign op_a = ctrl.a_is_pc ? pc : rs1_data;
    assign op_b = ctrl.b_is_imm ? ctrl.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb begin
        case (ctrl.alu_op)
            cpu_pkg::alu_sub: alu_result = op_a - op_b;
            cpu_pkg::alu_sll: alu_result = op_a << shamt;
            cpu_pkg::alu_slt: alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
            cpu_pkg::alu_sltu: alu_result = {31'b0, op_a < op_b};
            cpu_pkg::alu_xor: alu_result = op_a ^ op_b;
            cpu_pkg::alu_srl: alu_result = op_a >> shamt;
            cpu_pkg::alu_sra: alu_result = $unsigned($signed(op_a) >>> shamt);
            cpu_pkg::alu_or: alu_result = op_a | op_b;
            cpu_pkg::alu_and: alu_result = op_a & op_b;
            cpu_pkg::alu_pass_b: alu_result = op_b;
            default: alu_result = op_a + op_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (ctrl.br_funct)
            3'b000: taken = rs1_data == rs2_data;
            3'b001: taken = rs1_data != rs2_data;
            3'b100: taken = $signed(rs1_data) < $signed(rs2_data);
            3'b101: taken = $signed(rs1_data) >= $signed(rs2_data);
            3'b110: taken = rs1_data < rs2_data;
            3'b111: taken = rs1_data >= rs2_data;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && taken);
    assign target = ctrl.is_jalr ? ((rs1_data + ctrl.imm) & ~32'd1) : pc + ctrl.imm;

endmodule

`default_nettype wire

// File: hdl/cpu_csr.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_csr (
    input  wire                 clk,
    input  wire                 rst,
    input  wire cpu_pkg::ctrl_t ctrl,
    input  wire  [31:0]         pc,
    input  wire  [31:0]         rs1_data,
    output logic [31:0]         csr_rdata,
    output logic                trap,
    output logic [31:0]         trap_pc
);

    logic [31:0] mstatus;
    logic [31:0] mtvec;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] wdata;
    logic        wen;

    always_comb begin
        case (ctrl.csr_addr)
            cpu_pkg::csr_mstatus: csr_rdata = mstatus;
            cpu_pkg::csr_mtvec: csr_rdata = mtvec;
            cpu_pkg::csr_mepc: csr_rdata = mepc;
            cpu_pkg::csr_mcause: csr_rdata = mcause;
            default: csr_rdata = '0;
        endcase
    end

    // csrrs with rs1 = x0 is a pure read
    assign wen = (ctrl.csr_op == cpu_pkg::csr_write) ||
                 (ctrl.csr_op == cpu_pkg::csr_set && ctrl.rs1 != 4'd0);
    assign wdata = (ctrl.csr_op == cpu_pkg::csr_set) ? (csr_rdata | rs1_data) : rs1_data;

    assign trap = ctrl.is_ecall || ctrl.is_mret;
    assign trap_pc = ctrl.is_ecall ? mtvec : mepc;

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
            mtvec <= '0;
            mepc <= '0;
            mcause <= '0;
        end else if (ctrl.is_ecall) begin
            mepc <= pc;
            mcause <= cpu_pkg::cause_ecall_m;
            mstatus[cpu_pkg::mstatus_mpie] <= mstatus[cpu_pkg::mstatus_mie];
            mstatus[cpu_pkg::mstatus_mie] <= 1'b0;
        end else if (ctrl.is_mret) begin
            mstatus[cpu_pkg::mstatus_mie] <= mstatus[cpu_pkg::mstatus_mpie];
            mstatus[cpu_pkg::mstatus_mpie] <= 1'b1;
        end else if (wen) begin
            case (ctrl.csr_addr)
                cpu_pkg::csr_mstatus: mstatus <= wdata;
                // direct mode only, base is word aligned
                cpu_pkg::csr_mtvec: mtvec <= {wdata[31:2], 2'b00};
                cpu_pkg::csr_mepc: mepc <= {wdata[31:2], 2'b00};
                cpu_pkg::csr_mcause: mcause <= wdata;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_lsu (
    input  wire cpu_pkg::ctrl_t ctrl,
    input  wire  [31:0]         alu_result,
    input  wire  [31:0]         rs2_data,
    input  wire  [31:0]         pc,
    input  wire  [31:0]         csr_rdata,
    input  wire  [31:0]         dmem_rdata,
    output cpu_pkg::mem_req_t   dmem_req,
    output logic [31:0]         wb_data
);

    // word accesses only
    always_comb begin
        dmem_req.ren = ctrl.mem_read;
        dmem_req.wen = ctrl.mem_write;
        dmem_req.addr = {alu_result[31:2], 2'b00};
        dmem_req.wdata = rs2_data;
        dmem_req.wstrb = ctrl.mem_write ? 4'hf : 4'h0;
    end

    // writeback source
    always_comb begin
        if (ctrl.mem_read) begin
            wb_data = dmem_rdata;
        end else if (ctrl.csr_op != cpu_pkg::csr_none) begin
            wb_data = csr_rdata;
        end else if (ctrl.is_jal || ctrl.is_jalr) begin
            wb_data = pc + 32'd4;
        end else begin
            wb_data = alu_result;
        end
    end

endmodule

`default_nettype wire

// File: hdl/cpu_top.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
    input  wire                clk,
    input  wire                rst,
    output logic [31:0]        imem_addr,
    input  wire  [31:0]        imem_rdata,
    output cpu_pkg::mem_req_t  dmem_req,
    input  wire  [31:0]        dmem_rdata,
    output cpu_pkg::retire_t   retire
);

    logic [31:0]     pc;
    cpu_pkg::inst_u  inst;
    cpu_pkg::ctrl_t  ctrl;
    cpu_pkg::ctrl_t  ctrl_mem;
    logic [31:0]     rs1_data;
    logic [31:0]     rs2_data;
    logic [31:0]     alu_result;
    logic            redirect;
    logic [31:0]     target;
    logic [31:0]     csr_rdata;
    logic            trap;
    logic [31:0]     trap_pc;
    logic [31:0]     wb_data;

    cpu_ifu u_ifu (
        .clk      (clk),
        .rst      (rst),
        .redirect (redirect),
        .target   (target),
        .trap     (trap),
        .trap_pc  (trap_pc),
        .pc       (pc)
    );

    assign imem_addr = pc;
    assign inst = imem_rdata;

    cpu_idu u_idu (
        .inst (inst),
        .ctrl (ctrl)
    );

    cpu_regfile u_regfile (
        .clk    (clk),
        .rst    (rst),
        .wen    (ctrl.rd_wen),
        .waddr  (ctrl.rd),
        .wdata  (wb_data),
        .raddr1 (ctrl.rs1),
        .raddr2 (ctrl.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    cpu_exu u_exu (
        .ctrl       (ctrl),
        .pc         (pc),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .alu_result (alu_result),
        .redirect   (redirect),
        .target     (target)
    );

    cpu_csr u_csr (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (ctrl),
        .pc        (pc),
        .rs1_data  (rs1_data),
        .csr_rdata (csr_rdata),
        .trap      (trap),
        .trap_pc   (trap_pc)
    );

    // no memory traffic while held in reset
    always_comb begin
        ctrl_mem = ctrl;
        if (rst) begin
            ctrl_mem.mem_read = 1'b0;
            ctrl_mem.mem_write = 1'b0;
        end
    end

    cpu_lsu u_lsu (
        .ctrl       (ctrl_mem),
        .alu_result (alu_result),
        .rs2_data   (rs2_data),
        .pc         (pc),
        .csr_rdata  (csr_rdata),
        .dmem_rdata (dmem_rdata),
        .dmem_req   (dmem_req),
        .wb_data    (wb_data)
    );

    // one instruction retires every cycle out of reset
    always_comb begin
        retire.valid = !rst;
        retire.pc = pc;
        retire.rd_wen = ctrl.rd_wen;
        retire.rd = ctrl.rd;
        retire.rd_data = wb_data;
    end

endmodule

`default_nettype wire

// File: tb/tb_checks.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checks (
    input  wire                      clk,
    input  wire                      rst,
    input  wire  [31:0]              a,
    input  wire  [31:0]              b,
    input  wire cpu_pkg::retire_t    retire,
    input  wire cpu_pkg::mem_req_t   dmem_req,
    output logic                     failed,
    output logic                     done
);

    string       q_name [$];
    logic [31:0] q_pc [$];
    logic        q_wen [$];
    logic [3:0]  q_rd [$];
    logic [31:0] q_data [$];
    logic        mismatch_seen = 1'b0;
    logic        reset_fault = 1'b0;
    logic        table_done = 1'b0;
    logic        all_retired = 1'b0;

    assign failed = mismatch_seen || reset_fault;
    assign done = all_retired;

    // two's complement order from the sign bits, then magnitude
    function automatic logic signed_less(input logic [31:0] x, input logic [31:0] y);
        if (x[31] != y[31]) begin
            return x[31];
        end
        return x < y;
    endfunction

    // one bit at a time, copying the sign bit in from the top
    function automatic logic [31:0] arith_shift_right(input logic [31:0] v, input int n);
        logic [31:0] r;
        r = v;
        for (int i = 0; i < n; i++) begin
            r = {r[31], r[31:1]};
        end
        return r;
    endfunction

    task automatic add_rec(input string name, input logic [31:0] pc, input logic wen,
                           input logic [3:0] rd, input logic [31:0] data);
        q_name.push_back(name);
        q_pc.push_back(pc);
        q_wen.push_back(wen);
        q_rd.push_back(rd);
        q_data.push_back(data);
    endtask

    // branch at pc, filler x15 = 1 retires only on fall-through
    task automatic add_branch(input string name, input logic [31:0] pc, input logic taken);
        add_rec(name, pc, 1'b0, 4'd0, 32'd0);
        if (!taken) begin
            add_rec({name, " fall"}, pc + 32'd4, 1'b1, 4'd15, 32'd1);
        end
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp == act) else begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            mismatch_seen = 1'b1;
        end
    endtask

    initial begin
        @(negedge rst);
        add_rec("lw a", 32'd0, 1'b1, 4'd1, a);
        add_rec("lw b", 32'd4, 1'b1, 4'd2, b);
        add_rec("add", 32'd8, 1'b1, 4'd3, a + b);
        add_rec("sub", 32'd12, 1'b1, 4'd4, a - b);
        add_rec("sll", 32'd16, 1'b1, 4'd5, a << b[4:0]);
        add_rec("slt", 32'd20, 1'b1, 4'd6, signed_less(a, b) ? 32'd1 : 32'd0);
        add_rec("sltu", 32'd24, 1'b1, 4'd7, (a < b) ? 32'd1 : 32'd0);
        add_rec("xor", 32'd28, 1'b1, 4'd8, a ^ b);
        add_rec("srl", 32'd32, 1'b1, 4'd9, a >> b[4:0]);
        add_rec("sra", 32'd36, 1'b1, 4'd10, arith_shift_right(a, int'(b[4:0])));
        add_rec("or", 32'd40, 1'b1, 4'd11, a | b);
        add_rec("and", 32'd44, 1'b1, 4'd12, a & b);
        add_rec("addi", 32'd48, 1'b1, 4'd13, a + 32'hffff_fffb);
        add_rec("slti", 32'd52, 1'b1, 4'd13,
                signed_less(a, 32'hffff_ffff) ? 32'd1 : 32'd0);
        add_rec("sltiu", 32'd56, 1'b1, 4'd13, (a < 32'hffff_ffff) ? 32'd1 : 32'd0);
        add_rec("xori", 32'd60, 1'b1, 4'd13, a ^ 32'h555);
        add_rec("ori", 32'd64, 1'b1, 4'd13, a | 32'h0f0);
        add_rec("andi", 32'd68, 1'b1, 4'd13, a & 32'h7f0);
        add_rec("slli", 32'd72, 1'b1, 4'd13, a << 7);
        add_rec("srli", 32'd76, 1'b1, 4'd13, a >> 9);
        add_rec("srai", 32'd80, 1'b1, 4'd13, arith_shift_right(a, 9));
        add_rec("lui", 32'd84, 1'b1, 4'd14, 32'habcd_e000);
        add_rec("auipc", 32'd88, 1'b1, 4'd14, 32'd88 + 32'h1000);
        add_rec("add x0", 32'd92, 1'b0, 4'd0, 32'd0);
        add_branch("beq", 32'd96, a == b);
        add_branch("bne", 32'd104, a != b);
        add_branch("blt", 32'd112, signed_less(a, b));
        add_branch("bge", 32'd120, !signed_less(a, b));
        add_branch("bltu", 32'd128, a < b);
        add_branch("bgeu", 32'd136, a >= b);
        add_rec("jal", 32'd144, 1'b1, 4'd5, 32'd148);
        add_rec("addi base", 32'd156, 1'b1, 4'd6, 32'd176);
        add_rec("jalr", 32'd160, 1'b1, 4'd7, 32'd164);
        add_rec("sw", 32'd176, 1'b0, 4'd0, 32'd0);
        add_rec("lw back", 32'd180, 1'b1, 4'd8, a);
        add_rec("addi vec", 32'd184, 1'b1, 4'd9, 32'h200);
        add_rec("csrrw mtvec", 32'd188, 1'b1, 4'd10, 32'd0);
        add_rec("csrrs mtvec", 32'd192, 1'b1, 4'd11, 32'h200);
        add_rec("ecall", 32'd196, 1'b0, 4'd0, 32'd0);
        add_rec("read mepc", 32'h200, 1'b1, 4'd12, 32'd196);
        add_rec("read mcause", 32'h204, 1'b1, 4'd13, 32'd11);
        add_rec("mepc plus 4", 32'h208, 1'b1, 4'd12, 32'd200);
        add_rec("write mepc", 32'h20c, 1'b0, 4'd0, 32'd0);
        add_rec("mret", 32'h210, 1'b0, 4'd0, 32'd0);
        add_rec("self loop", 32'd200, 1'b0, 4'd0, 32'd0);
        table_done = 1'b1;
    end

    // nothing retires and no memory strobe is active in reset
    reset_quiet: assert property (@(posedge clk)
        rst |-> (!retire.valid && !dmem_req.wen && !dmem_req.ren))
    else begin
        $display("retire or data memory strobe was active during reset");
        reset_fault = 1'b1;
    end

    always @(posedge clk) begin
        if (!rst && retire.valid && table_done && !failed && !done) begin
            check({q_name[0], " pc"}, q_pc[0], retire.pc);
            check({q_name[0], " rd_wen"}, 32'(q_wen[0]), 32'(retire.rd_wen));
            if (q_wen[0]) begin
                check({q_name[0], " rd"}, 32'(q_rd[0]), 32'(retire.rd));
                check({q_name[0], " rd_data"}, q_data[0], retire.rd_data);
            end
            // loads of A, B and the reload
            check({q_name[0], " dmem ren"},
                  32'((q_pc[0] == 32'd0) || (q_pc[0] == 32'd4) || (q_pc[0] == 32'd180)),
                  32'(dmem_req.ren));
            check({q_name[0], " dmem wen"}, 32'(q_pc[0] == 32'd176), 32'(dmem_req.wen));
            if (q_pc[0] == 32'd176) begin
                check("store addr", 32'h108, dmem_req.addr);
                check("store wdata", a, dmem_req.wdata);
                check("store wstrb", 32'hf, 32'(dmem_req.wstrb));
            end
            void'(q_name.pop_front());
            void'(q_pc.pop_front());
            void'(q_wen.pop_front());
            void'(q_rd.pop_front());
            void'(q_data.pop_front());
            all_retired = (q_pc.size() == 0) && !mismatch_seen;
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top;

    logic              clk;
    logic              rst;
    logic [31:0]       imem_addr;
    logic [31:0]       imem_rdata;
    cpu_pkg::mem_req_t dmem_req;
    logic [31:0]       dmem_rdata;
    cpu_pkg::retire_t  retire;
    logic [31:0]       a;
    logic [31:0]       b;
    logic              failed;
    logic              done;
    logic [31:0]       imem [256];
    logic [31:0]       dmem [256];
    logic [31:0]       fill_pc;
    int                n_words;

    cpu_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .imem_addr  (imem_addr),
        .imem_rdata (imem_rdata),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .retire     (retire)
    );

    tb_checks u_checks (
        .clk      (clk),
        .rst      (rst),
        .a        (a),
        .b        (b),
        .retire   (retire),
        .dmem_req (dmem_req),
        .failed   (failed),
        .done     (done)
    );

    // memories answer in the same cycle
    assign imem_rdata = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.addr[9:2]];

    always @(posedge clk) begin
        if (dmem_req.wen) begin
            for (int i = 0; i < 4; i++) begin
                if (dmem_req.wstrb[i]) begin
                    dmem[dmem_req.addr[9:2]][i*8 +: 8] <= dmem_req.wdata[i*8 +: 8];
                end
            end
        end
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        cpu_pkg::inst_u w;
        w.r_fmt.funct7 = f7;
        w.r_fmt.rs2 = rs2;
        w.r_fmt.rs1 = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd = rd;
        w.r_fmt.opcode = cpu_pkg::opc_op;
        return w;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        cpu_pkg::inst_u w;
        w.i_fmt.imm_11_0 = imm;
        w.i_fmt.rs1 = rs1;
        w.i_fmt.funct3 = f3;
        w.i_fmt.rd = rd;
        w.i_fmt.opcode = opc;
        return w;
    endfunction

    // store word
    function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1);
        cpu_pkg::inst_u w;
        w.s_fmt.imm_11_5 = imm[11:5];
        w.s_fmt.rs2 = rs2;
        w.s_fmt.rs1 = rs1;
        w.s_fmt.funct3 = 3'b010;
        w.s_fmt.imm_4_0 = imm[4:0];
        w.s_fmt.opcode = cpu_pkg::opc_store;
        return w;
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        cpu_pkg::inst_u w;
        w.b_fmt.imm_12 = imm[12];
        w.b_fmt.imm_10_5 = imm[10:5];
        w.b_fmt.rs2 = rs2;
        w.b_fmt.rs1 = rs1;
        w.b_fmt.funct3 = f3;
        w.b_fmt.imm_4_1 = imm[4:1];
        w.b_fmt.imm_11 = imm[11];
        w.b_fmt.opcode = cpu_pkg::opc_branch;
        return w;
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                          input logic [6:0] opc);
        cpu_pkg::inst_u w;
        w.u_fmt.imm_31_12 = imm;
        w.u_fmt.rd = rd;
        w.u_fmt.opcode = opc;
        return w;
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
        cpu_pkg::inst_u w;
        w.j_fmt.imm_20 = imm[20];
        w.j_fmt.imm_10_1 = imm[10:1];
        w.j_fmt.imm_11 = imm[11];
        w.j_fmt.imm_19_12 = imm[19:12];
        w.j_fmt.rd = rd;
        w.j_fmt.opcode = cpu_pkg::opc_jal;
        return w;
    endfunction

    task automatic put(input logic [31:0] word);
        imem[fill_pc[9:2]] = word;
        fill_pc = fill_pc + 32'd4;
        n_words++;
    endtask

    task automatic build_program();
        logic [6:0] sys;
        sys = cpu_pkg::opc_system;
        fill_pc = cpu_pkg::reset_vector;
        // A and B
        put(enc_i(12'h100, 5'd0, 3'b010, 5'd1, cpu_pkg::opc_load));
        put(enc_i(12'h104, 5'd0, 3'b010, 5'd2, cpu_pkg::opc_load));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
        put(enc_r(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b001, 5'd5));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b010, 5'd6));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b011, 5'd7));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b100, 5'd8));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b101, 5'd9));
        put(enc_r(7'h20, 5'd2, 5'd1, 3'b101, 5'd10));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b110, 5'd11));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b111, 5'd12));
        put(enc_i(12'hffb, 5'd1, 3'b000, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_i(12'hfff, 5'd1, 3'b010, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_i(12'hfff, 5'd1, 3'b011, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_i(12'h555, 5'd1, 3'b100, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_i(12'h0f0, 5'd1, 3'b110, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_i(12'h7f0, 5'd1, 3'b111, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_i(12'h007, 5'd1, 3'b001, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_i(12'h009, 5'd1, 3'b101, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_i(12'h409, 5'd1, 3'b101, 5'd13, cpu_pkg::opc_op_imm));
        put(enc_u(20'habcde, 5'd14, cpu_pkg::opc_lui));
        put(enc_u(20'h00001, 5'd14, cpu_pkg::opc_auipc));
        put(enc_r(7'h00, 5'd2, 5'd1, 3'b000, 5'd0));
        // six branches, each skipping one filler when taken
        for (int f = 0; f < 8; f++) begin
            if (f != 2 && f != 3) begin
                put(enc_b(13'd8, 5'd2, 5'd1, 3'(f)));
                put(enc_i(12'h001, 5'd0, 3'b000, 5'd15, cpu_pkg::opc_op_imm));
            end
        end
        put(enc_j(21'd12, 5'd5));
        put(enc_i(12'h002, 5'd0, 3'b000, 5'd15, cpu_pkg::opc_op_imm));
        put(enc_i(12'h002, 5'd0, 3'b000, 5'd15, cpu_pkg::opc_op_imm));
        put(enc_i(12'd176, 5'd0, 3'b000, 5'd6, cpu_pkg::opc_op_imm));
        put(enc_i(12'h001, 5'd6, 3'b000, 5'd7, cpu_pkg::opc_jalr));
        for (int k = 0; k < 3; k++) begin
            put(enc_i(12'h002, 5'd0, 3'b000, 5'd15, cpu_pkg::opc_op_imm));
        end
        put(enc_s(12'h108, 5'd1, 5'd0));
        put(enc_i(12'h108, 5'd0, 3'b010, 5'd8, cpu_pkg::opc_load));
        put(enc_i(12'h200, 5'd0, 3'b000, 5'd9, cpu_pkg::opc_op_imm));
        put(enc_i(cpu_pkg::csr_mtvec, 5'd9, 3'b001, 5'd10, sys));
        put(enc_i(cpu_pkg::csr_mtvec, 5'd0, 3'b010, 5'd11, sys));
        put(enc_i(12'h000, 5'd0, 3'b000, 5'd0, sys));
        // final self-loop
        put(enc_j(21'd0, 5'd0));
        // trap handler
        fill_pc = 32'h200;
        put(enc_i(cpu_pkg::csr_mepc, 5'd0, 3'b010, 5'd12, sys));
        put(enc_i(cpu_pkg::csr_mcause, 5'd0, 3'b010, 5'd13, sys));
        put(enc_i(12'h004, 5'd12, 3'b000, 5'd12, cpu_pkg::opc_op_imm));
        put(enc_i(cpu_pkg::csr_mepc, 5'd12, 3'b001, 5'd0, sys));
        put(enc_i(12'h302, 5'd0, 3'b000, 5'd0, sys));
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        n_words = 0;
        void'($urandom(86687));
        a = $urandom;
        b = $urandom;
        for (int i = 0; i < 256; i++) begin
            // nop everywhere else, its immediate tagged with the word index
            imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, cpu_pkg::opc_op_imm);
            dmem[i] = 32'hd00d_0000 ^ (32'(i) * 32'h0004_0404);
        end
        dmem[64] = a;
        dmem[65] = b;
        build_program();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    initial begin
        wait (failed || done);
        if (failed) begin
            $display("Simulation failed");
            $fatal(1, "stopping after first error");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

    // watchdog
    initial begin
        #1;
        #((n_words + 20) * 40);
        $display("program did not reach its final loop in time");
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

// File: sources.f
hdl/cpu_pkg.sv
hdl/cpu_ifu.sv
hdl/cpu_idu.sv
hdl/cpu_regfile.sv
hdl/cpu_exu.sv
hdl/cpu_csr.sv
hdl/cpu_lsu.sv
hdl/cpu_top.sv
tb/tb_checks.sv
tb/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f sources.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

exit 0
